// File: lsu_stimulus.txt
// num we size ext operand_a operand_b useincr wdata regoff misaligned expected
// we 1 = store, size 0 word 1 half 2/3 byte, ext 0 zero 2 ones else sign, words in hex
1  1 0 0 00000040 00000008 1 deadbeef 0 0 00000000
2  0 0 0 00000048 00001234 0 00000000 0 0 deadbeef
3  0 2 1 0000000c 00000002 1 00000000 0 0 0000007e
4  0 2 3 00000010 00000001 1 00000000 0 0 ffffff81
5  0 3 0 00000013 00000000 0 00000000 0 0 00000083
6  0 2 2 0000000f 00000000 0 00000000 0 0 ffffff7f
7  0 1 1 00000010 00000002 1 00000000 0 0 ffff8382
8  0 1 0 00000015 00000000 0 00000000 0 0 00008685
9  0 1 2 00000008 00000000 0 00000000 0 0 ffff7978
10 1 2 0 00000051 00000000 0 000000aa 0 0 00000000
11 1 1 0 00000050 00000002 1 00001234 0 0 00000000
12 1 2 0 00000050 00000000 0 00550000 2 0 00000000
13 0 0 0 00000050 00000000 0 00000000 0 0 1234aa55
14 1 0 0 00000060 00000001 1 11223344 0 1 00000000
15 0 0 0 00000061 00000000 0 00000000 0 1 11223344
16 0 0 0 00000060 00000003 1 00000000 0 1 d6d51122
17 1 1 0 00000073 00000000 0 0000beef 0 1 00000000
18 0 1 1 00000073 00000000 0 00000000 0 1 ffffbeef
19 0 0 0 00000042 00000000 0 00000000 0 1 b5b4b3b2
20 0 1 0 0000000f 00000000 0 00000000 0 1 0000807f

// File: lsu.f
lsu_pkg.sv
lsu_trans_if.sv
lsu_req_gen.sv
lsu_txn_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
  import lsu_pkg::*;

  localparam int DEPTH        = 2;
  localparam int CLK_PERIOD   = 20;   // ns
  localparam int MAX_TESTS    = 64;
  localparam int CYC_PER_TEST = 200;  // watchdog budget per stimulus line

  logic            clk;
  logic            rst_n;
  logic            data_req, data_gnt, data_rvalid, data_we;
  logic [XLEN-1:0] data_addr, data_wdata, data_rdata;
  logic [BE_W-1:0] data_be;
  logic            data_we_ex, data_req_ex, addr_useincr_ex, data_misaligned_ex;
  logic [1:0]      data_type_ex, data_reg_offset_ex, data_sign_ext_ex;
  logic [XLEN-1:0] data_wdata_ex, operand_a_ex, operand_b_ex, data_rdata_ex;
  logic            data_misaligned, lsu_ready_ex, lsu_ready_wb, busy;

  // stimulus table with one entry per file line
  int              t_num [MAX_TESTS];
  logic            t_we [MAX_TESTS];
  logic            t_incr [MAX_TESTS];
  logic            t_mis [MAX_TESTS];
  logic [1:0]      t_size [MAX_TESTS];
  logic [1:0]      t_ext [MAX_TESTS];
  logic [1:0]      t_regoff [MAX_TESTS];
  logic [XLEN-1:0] t_opa [MAX_TESTS];
  logic [XLEN-1:0] t_opb [MAX_TESTS];
  logic [XLEN-1:0] t_wdata [MAX_TESTS];
  logic [XLEN-1:0] t_exp [MAX_TESTS];
  int              n_tests;
  bit              stim_loaded;
  int              err_cnt;
  int              pass_cnt;
  int              fail_cnt;
  // bus monitor
  int              outstanding;  // granted and not answered yet
  bit              req_waiting;  // req seen without gnt
  logic [XLEN-1:0] held_addr;
  logic [BE_W-1:0] held_be;
  logic [XLEN-1:0] held_wdata;

  lsu_top #(
    .DEPTH (DEPTH)
  ) u_lsu_top (
    .clk (clk), .rst_n (rst_n),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_addr_o (data_addr), .data_we_o (data_we), .data_be_o (data_be),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata),
    .data_we_ex_i (data_we_ex), .data_type_ex_i (data_type_ex),
    .data_wdata_ex_i (data_wdata_ex), .data_reg_offset_ex_i (data_reg_offset_ex),
    .data_sign_ext_ex_i (data_sign_ext_ex), .data_rdata_ex_o (data_rdata_ex),
    .data_req_ex_i (data_req_ex), .operand_a_ex_i (operand_a_ex),
    .operand_b_ex_i (operand_b_ex), .addr_useincr_ex_i (addr_useincr_ex),
    .data_misaligned_ex_i (data_misaligned_ex), .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o (lsu_ready_ex), .lsu_ready_wb_o (lsu_ready_wb), .busy_o (busy)
  );

  tb_lsu_mem u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (data_req), .addr_i (data_addr),
    .we_i (data_we), .be_i (data_be), .wdata_i (data_wdata),
    .gnt_o (data_gnt), .rvalid_o (data_rvalid), .rdata_o (data_rdata)
  );

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("Fail %0t %s expected %h got %h", $time, sig, exp, got);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error %0t %s", $time, msg);
    err_cnt++;
  endtask

  // lanes an access covers up to the word edge
  // the 2nd phase holds the spill from lane 0 up
  function automatic logic [3:0] lanes_for(input logic [1:0] size, input int offset,
                                           input bit second);
    int         n;
    int         first;
    int         last;
    int         l;
    logic [3:0] be;
    n  = (size == 2'd0) ? 4 : (size == 2'd1) ? 2 : 1;
    be = '0;
    first = second ? 0 : offset;
    last  = second ? offset + n - 5 : offset + n - 1;
    if (last > 3)
      last = 3;
    for (l = first; l <= last; l++)
      be[l] = 1'b1;
    return be;
  endfunction

  task automatic load_stimulus();
    int               fd;
    int               cnt;
    int               f_num, f_we, f_size, f_ext, f_incr, f_regoff, f_mis;
    logic [31:0]      f_opa, f_opb, f_wdata, f_exp;
    logic [8*160-1:0] line_buf;
    fd = $fopen("lsu_stimulus.txt", "r");
    if (fd == 0)
    begin
      report_error("cannot open lsu_stimulus.txt");
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS)
    begin
      line_buf = '0;
      cnt = $fgets(line_buf, fd);
      cnt = $sscanf(line_buf, "%d %d %d %d %h %h %d %h %d %d %h", f_num, f_we, f_size,
                    f_ext, f_opa, f_opb, f_incr, f_wdata, f_regoff, f_mis, f_exp);
      if (cnt == 11)  // header and blank lines fall out here
      begin
        t_num[n_tests]    = f_num;
        t_we[n_tests]     = f_we[0];
        t_size[n_tests]   = f_size[1:0];
        t_ext[n_tests]    = f_ext[1:0];
        t_opa[n_tests]    = f_opa;
        t_opb[n_tests]    = f_opb;
        t_incr[n_tests]   = f_incr[0];
        t_wdata[n_tests]  = f_wdata;
        t_regoff[n_tests] = f_regoff[1:0];
        t_mis[n_tests]    = f_mis[0];
        t_exp[n_tests]    = f_exp;
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  // execute stage view of one phase
  task automatic drive_access(input int k, input bit second);
    data_req_ex        = 1'b1;
    data_we_ex         = t_we[k];
    data_type_ex       = t_size[k];
    data_sign_ext_ex   = t_ext[k];
    data_wdata_ex      = t_wdata[k];
    data_reg_offset_ex = t_regoff[k];
    operand_a_ex       = second ? t_opa[k] + 32'd4 : t_opa[k];  // next word at the same offset
    operand_b_ex       = t_opb[k];
    addr_useincr_ex    = t_incr[k];
    data_misaligned_ex = second;
  endtask

  task automatic run_test(input int k);
    logic [31:0] addr;
    int          offset;
    int          phase;
    int          nphases;
    int          errs_before;
    bit          handshake;
    errs_before = err_cnt;
    addr    = t_incr[k] ? t_opa[k] + t_opb[k] : t_opa[k];
    offset  = addr[1:0];
    phase   = 0;
    nphases = 1;
    while (phase < nphases)
    begin
      @(negedge clk);
      drive_access(k, phase == 1);
      handshake = 1'b0;
      while (!handshake)
      begin
        @(posedge clk);
        if (data_req && data_gnt && data_we && data_be !== lanes_for(t_size[k], offset, phase == 1))
          report_mismatch("data_be_o", lanes_for(t_size[k], offset, phase == 1), data_be);
        handshake = lsu_ready_ex;
      end
      if (phase == 0)
      begin
        if (data_misaligned !== t_mis[k])
          report_mismatch("data_misaligned_o", t_mis[k], data_misaligned);
        if (data_misaligned === 1'b1)
          nphases = 2;  // ask for the spill
      end
      else if (data_misaligned !== 1'b0)
        report_mismatch("data_misaligned_o", 32'd0, data_misaligned);  // no split in phase 2
      phase++;
    end
    @(negedge clk);
    data_req_ex        = 1'b0;
    data_misaligned_ex = 1'b0;
    @(posedge clk);
    while (data_rvalid !== 1'b1)  // rvalid of the last phase ends the access
      @(posedge clk);
    if (!t_we[k] && data_rdata_ex !== t_exp[k])
      report_mismatch("data_rdata_ex_o", t_exp[k], data_rdata_ex);
    @(posedge clk);
    if (busy !== 1'b0)
      report_mismatch("busy_o", 32'd0, busy);
    if (err_cnt == errs_before)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0d %s", t_num[k], (err_cnt == errs_before) ? "pass" : "fail");
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // bus monitor
  //////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (req_waiting)  // last cycle had req without gnt
      begin
        if (data_req !== 1'b1)
          report_error("data_req_o dropped before grant");
        if (data_req === 1'b1 && data_addr !== held_addr)
          report_mismatch("data_addr_o", held_addr, data_addr);
        if (data_req === 1'b1 && data_be !== held_be)
          report_mismatch("data_be_o", held_be, data_be);
        if (data_req === 1'b1 && data_wdata !== held_wdata)
          report_mismatch("data_wdata_o", held_wdata, data_wdata);
      end
      req_waiting = data_req && !data_gnt;
      held_addr   = data_addr;
      held_be     = data_be;
      held_wdata  = data_wdata;
      if (data_req && data_gnt)
        outstanding++;
      if (outstanding > DEPTH)
        report_error("more transactions outstanding than DEPTH allows");
      if (data_rvalid && outstanding == 0)
        report_error("rvalid arrived with nothing outstanding");
      else if (data_rvalid)
        outstanding--;
    end
  end

  // watchdog
  initial
  begin
    wait (stim_loaded);
    repeat (CYC_PER_TEST * n_tests) @(posedge clk);
    $display("Error watchdog expired after %0d cycles, run did not finish",
             CYC_PER_TEST * n_tests);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int errs_before;
    int k;
    rst_n              = 1'b0;
    data_req_ex        = 1'b0;
    data_we_ex         = 1'b0;
    data_type_ex       = 2'b00;
    data_wdata_ex      = '0;
    data_reg_offset_ex = 2'b00;
    data_sign_ext_ex   = 2'b00;
    operand_a_ex       = '0;
    operand_b_ex       = '0;
    addr_useincr_ex    = 1'b0;
    data_misaligned_ex = 1'b0;
    load_stimulus();
    if (n_tests == 0)
      report_error("no stimulus lines read");
    stim_loaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    errs_before = err_cnt;
    if (data_req !== 1'b0)
      report_mismatch("data_req_o", 32'd0, data_req);
    if (busy !== 1'b0)
      report_mismatch("busy_o", 32'd0, busy);
    if (data_misaligned !== 1'b0)
      report_mismatch("data_misaligned_o", 32'd0, data_misaligned);
    if (lsu_ready_wb !== 1'b1)
      report_mismatch("lsu_ready_wb_o", 32'd1, lsu_ready_wb);
    $display("reset check %s", (err_cnt == errs_before) ? "pass" : "fail");
    for (k = 0; k < n_tests; k++)
      run_test(k);
    $display("summary %0d tests, %0d passed, %0d failed, %0d errors",
             n_tests, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb_lsu_mem.sv
`timescale 1ns/1ps

module tb_lsu_mem (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_i,
  input  logic [lsu_pkg::XLEN-1:0] addr_i,
  input  logic                     we_i,
  input  logic [lsu_pkg::BE_W-1:0] be_i,
  input  logic [lsu_pkg::XLEN-1:0] wdata_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_o
);
  import lsu_pkg::*;

  localparam int          MEM_WORDS = 64;
  localparam int          IDX_W     = $clog2(MEM_WORDS);
  localparam logic [31:0] LCG_SEED  = 32'h7d0f_49ae;

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;          // word index, byte address bits above the lane
  logic [31:0]      lcg_state;
  logic             accepted;     // req and gnt seen at the last rising edge
  logic [XLEN-1:0]  resp_word;    // word read at acceptance

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign idx = addr_i[IDX_W+1:2];

  initial
  begin
    for (int i = 0; i < MEM_WORDS; i++)
      for (int b = 0; b < BE_W; b++)
        mem[i][8*b +: 8] = 8'(4*i + b) + 8'h70;  // byte at address a holds a + 0x70
    gnt_o     = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    accepted  = 1'b0;
    resp_word = '0;
    lcg_state = LCG_SEED;
  end

  // accept on the rising edge, merge only the enabled lanes
  always @(posedge clk)
  begin
    accepted <= 1'b0;
    if (rst_n && req_i && gnt_o)
    begin
      accepted  <= 1'b1;
      resp_word <= mem[idx];  // old word, reads see earlier stores
      for (int b = 0; b < BE_W; b++)
        if (we_i && be_i[b])
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      lcg_state <= LCG_SEED;
      gnt_o     <= 1'b0;
      rvalid_o  <= 1'b0;
    end
    else
    begin
      lcg_state <= lcg_next(lcg_state);
      gnt_o     <= (lcg_state[31:30] != 2'b00);   // grant about 3 cycles in 4
      rvalid_o  <= accepted;                      // one cycle after the grant
      rdata_o   <= resp_word;
    end
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // data bus
  output logic                     data_req_o,
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  output logic [lsu_pkg::XLEN-1:0] data_addr_o,
  output logic                     data_we_o,
  output logic [lsu_pkg::BE_W-1:0] data_be_o,
  output logic [lsu_pkg::XLEN-1:0] data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i,
  // execute stage
  input  logic                     data_we_ex_i,
  input  logic [1:0]               data_type_ex_i,        // 00 word, 01 half, 1x byte
  input  logic [lsu_pkg::XLEN-1:0] data_wdata_ex_i,
  input  logic [1:0]               data_reg_offset_ex_i,
  input  logic [1:0]               data_sign_ext_ex_i,    // 00 zero, 10 ones, else sign
  output logic [lsu_pkg::XLEN-1:0] data_rdata_ex_o,
  input  logic                     data_req_ex_i,
  input  logic [lsu_pkg::XLEN-1:0] operand_a_ex_i,
  input  logic [lsu_pkg::XLEN-1:0] operand_b_ex_i,
  input  logic                     addr_useincr_ex_i,
  input  logic                     data_misaligned_ex_i,
  output logic                     data_misaligned_o,
  // stalls
  output logic                     lsu_ready_ex_o,
  output logic                     lsu_ready_wb_o,
  output logic                     busy_o
);
  import lsu_pkg::*;

  lsu_offset_t addr_offset;  // byte offset, ex to wb
  logic        ctrl_update;

  lsu_trans_if trans_if ();

  assign trans_if.trans_ready = data_gnt_i;  // accepted on req and gnt

  lsu_req_gen u_req_gen (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_we_i         (data_we_ex_i),
    .data_type_i       (lsu_type_e'(data_type_ex_i)),
    .data_wdata_i      (data_wdata_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .data_req_i        (data_req_ex_i),
    .data_misaligned_i (data_misaligned_ex_i),
    .data_misaligned_o (data_misaligned_o),
    .addr_offset_o     (addr_offset),
    .trans             (trans_if.gen)
  );

  lsu_txn_ctrl #(
    .DEPTH (DEPTH)
  ) u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .trans          (trans_if.ctrl),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .ctrl_update_o  (ctrl_update),
    .busy_o         (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk                  (clk),
    .rst_n                (rst_n),
    .ctrl_update_i        (ctrl_update),
    .data_we_i            (data_we_ex_i),
    .data_type_i          (lsu_type_e'(data_type_ex_i)),
    .data_sign_ext_i      (lsu_ext_e'(data_sign_ext_ex_i)),
    .addr_offset_i        (addr_offset),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .resp                 (trans_if.sink),
    .data_rdata_o         (data_rdata_ex_o)
  );

endmodule

// File: lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ctrl_update_i,        // access moves on to wb
  input  logic                     data_we_i,
  input  lsu_pkg::lsu_type_e       data_type_i,
  input  lsu_pkg::lsu_ext_e        data_sign_ext_i,
  input  lsu_pkg::lsu_offset_t     addr_offset_i,
  input  logic                     data_misaligned_ex_i, // 2nd phase in ex
  input  logic                     data_misaligned_i,    // 1st phase of a split in ex
  lsu_trans_if.sink                resp,
  output logic [lsu_pkg::XLEN-1:0] data_rdata_o
);
  import lsu_pkg::*;

  lsu_type_e       data_type_q;
  lsu_ext_e        data_sign_ext_q;
  lsu_offset_t     rdata_offset_q;
  logic            data_we_q;

  logic [XLEN-1:0] rdata_q;         // first word of a split, else last result
  logic [XLEN-1:0] rdata_w;         // word, joined if split
  logic [15:0]     rdata_h;         // raw half
  logic [7:0]      rdata_b;         // raw byte
  logic [XLEN-1:0] data_rdata_ext;

  // upper fill bit for the current mode
  function automatic logic fill_bit(input lsu_ext_e mode, input logic msb);
    case (mode)
      EXT_ZERO: return 1'b0;
      EXT_ONES: return 1'b1;
      default:  return msb;      // sign, also code 11
    endcase
  endfunction

  //////////////////////////////
  // wb control registers
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q     <= LSU_WORD;
      data_sign_ext_q <= EXT_ZERO;
      rdata_offset_q  <= '0;
      data_we_q       <= 1'b0;
    end
    else if (ctrl_update_i)
    begin
      data_type_q     <= data_type_i;
      data_sign_ext_q <= data_sign_ext_i;
      rdata_offset_q  <= addr_offset_i;   // same offset in both phases
      data_we_q       <= data_we_i;
    end
  end

  //////////////////////////////
  // lane select and join
  //////////////////////////////

  // split word, low bytes sit at the top of the held first word
  always_comb
  begin
    case (rdata_offset_q)
      2'b00:   rdata_w = resp.resp_rdata;
      2'b01:   rdata_w = {resp.resp_rdata[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {resp.resp_rdata[15:0], rdata_q[31:16]};
      default: rdata_w = {resp.resp_rdata[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb
  begin
    case (rdata_offset_q)
      2'b00:   rdata_h = resp.resp_rdata[15:0];
      2'b01:   rdata_h = resp.resp_rdata[23:8];
      2'b10:   rdata_h = resp.resp_rdata[31:16];
      default: rdata_h = {resp.resp_rdata[7:0], rdata_q[31:24]};  // split half
    endcase
  end

  assign rdata_b = resp.resp_rdata[{rdata_offset_q, 3'b000} +: 8];

  // extension
  always_comb
  begin
    case (data_type_q)
      LSU_WORD: data_rdata_ext = rdata_w;
      LSU_HALF: data_rdata_ext = {{(XLEN-16){fill_bit(data_sign_ext_q, rdata_h[15])}}, rdata_h};
      default:  data_rdata_ext = {{(XLEN-8){fill_bit(data_sign_ext_q, rdata_b[7])}}, rdata_b};
    endcase
  end

  // holding register, loads only
  always_ff @(posedge clk)
  begin
    if (resp.resp_valid && !data_we_q)
    begin
      if (data_misaligned_ex_i || data_misaligned_i)
        rdata_q <= resp.resp_rdata;   // keep raw first word for the join
      else
        rdata_q <= data_rdata_ext;
    end
  end

  // live on rvalid, held value otherwise
  assign data_rdata_o = resp.resp_valid ? data_rdata_ext : rdata_q;

endmodule

// File: lsu_txn_ctrl.sv
`timescale 1ns/1ps

module lsu_txn_ctrl #(
  parameter int unsigned DEPTH = 2  // max outstanding transactions
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     data_req_ex_i,   // execute stage wants an access
  input  logic                     data_gnt_i,
  input  logic                     data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] data_rdata_i,
  lsu_trans_if.ctrl                trans,
  output logic                     data_req_o,
  output logic [lsu_pkg::XLEN-1:0] data_addr_o,
  output logic                     data_we_o,
  output logic [lsu_pkg::BE_W-1:0] data_be_o,
  output logic [lsu_pkg::XLEN-1:0] data_wdata_o,
  output logic                     lsu_ready_ex_o,
  output logic                     lsu_ready_wb_o,
  output logic                     ctrl_update_o,   // load wb control registers
  output logic                     busy_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] cnt_q;       // outstanding txns
  logic [CNT_W-1:0] cnt_d;
  logic             count_up;    // request accepted
  logic             count_down;  // response returned

  //////////////////////////////
  // request issue
  //////////////////////////////

  // no rvalid in this path, only the registered count
  assign trans.trans_valid = data_req_ex_i && (cnt_q < CNT_W'(DEPTH));
  assign trans.resp_valid  = data_rvalid_i;
  assign trans.resp_rdata  = data_rdata_i;

  // request fields are held stable by the execute stage, so straight to the bus
  assign data_req_o   = trans.trans_valid;
  assign data_addr_o  = trans.trans_addr;
  assign data_we_o    = trans.trans_we;
  assign data_be_o    = trans.trans_be;
  assign data_wdata_o = trans.trans_wdata;

  assign count_up   = trans.trans_valid && trans.trans_ready;
  assign count_down = trans.resp_valid;

  // stage readiness
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : trans.resp_valid;

  always_comb
  begin
    if (!data_req_ex_i)
      lsu_ready_ex_o = 1'b1;                          // idle ex stage
    else if (cnt_q == '0)
      lsu_ready_ex_o = count_up;                      // wb free, go on acceptance
    else if (cnt_q == CNT_W'(1))
      lsu_ready_ex_o = count_up && trans.resp_valid;  // wb frees in the same cycle
    else
      lsu_ready_ex_o = trans.resp_valid;
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o        = (cnt_q != '0) || trans.trans_valid;

  //////////////////////////////
  // outstanding counter
  //////////////////////////////

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;          // none or both
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  a_cnt_max : assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= CNT_W'(DEPTH));
  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0));
  a_req_known : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown({data_addr_o, data_we_o, data_be_o}));
  // waiting request keeps its fields until granted
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o)
    && $stable(data_be_o) && $stable(data_we_o) && $stable(data_wdata_o)));

endmodule

// File: lsu_req_gen.sv
`timescale 1ns/1ps

module lsu_req_gen (
  input  logic [lsu_pkg::XLEN-1:0] operand_a_i,        // base register
  input  logic [lsu_pkg::XLEN-1:0] operand_b_i,        // offset or increment
  input  logic                     addr_useincr_i,     // 1 = a + b, 0 = a
  input  logic                     data_we_i,
  input  lsu_pkg::lsu_type_e       data_type_i,
  input  logic [lsu_pkg::XLEN-1:0] data_wdata_i,
  input  lsu_pkg::lsu_offset_t     data_reg_offset_i,  // lane of the store data in the register
  input  logic                     data_req_i,
  input  logic                     data_misaligned_i,  // second phase of a split access
  output logic                     data_misaligned_o,  // split needed, ask for a 2nd phase
  output lsu_pkg::lsu_offset_t     addr_offset_o,      // byte offset for the read path
  lsu_trans_if.gen                 trans
);
  import lsu_pkg::*;

  logic [XLEN-1:0] data_addr_int;  // effective address
  lsu_offset_t     wdata_offset;   // rotation amount for store data

  //////////////////////////////
  // address
  //////////////////////////////

  assign data_addr_int = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_offset_o = data_addr_int[1:0];

  // 2nd phase always hits the following word from lane 0 up
  assign trans.trans_addr = data_misaligned_i ? {data_addr_int[XLEN-1:2], 2'b00}
                                              : data_addr_int;
  assign trans.trans_we   = data_we_i;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb
  begin
    case (data_type_i)
      LSU_WORD:
      begin
        if (!data_misaligned_i)
          trans.trans_be = 4'b1111 << data_addr_int[1:0];    // low part, up to lane 3
        else
          trans.trans_be = ~(4'b1111 << data_addr_int[1:0]); // spill into next word
      end
      LSU_HALF:
      begin
        if (!data_misaligned_i)
          trans.trans_be = 4'b0011 << data_addr_int[1:0];    // offset 3 keeps lane 3 only
        else
          trans.trans_be = 4'b0001;                          // upper byte of the half
      end
      default: trans.trans_be = 4'b0001 << data_addr_int[1:0]; // byte, also code 11
    endcase
  end

  //////////////////////////////
  // store data rotation
  //////////////////////////////

  // move the register lane onto the bus lane
  // in the 2nd phase the same rotation puts the leftover bytes at lane 0
  assign wdata_offset = data_addr_int[1:0] - data_reg_offset_i;

  always_comb
  begin
    case (wdata_offset)
      2'b00:   trans.trans_wdata = data_wdata_i;
      2'b01:   trans.trans_wdata = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'b10:   trans.trans_wdata = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: trans.trans_wdata = {data_wdata_i[7:0],  data_wdata_i[31:8]};
    endcase
  end

  // misalignment check, first phase only
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_i)
    begin
      case (data_type_i)
        LSU_WORD: data_misaligned_o = (data_addr_int[1:0] != 2'b00);
        LSU_HALF: data_misaligned_o = (data_addr_int[1:0] == 2'b11);
        default:  data_misaligned_o = 1'b0;  // bytes never cross a word
      endcase
    end
  end

  // a word 2nd phase at offset 0 would give no lanes
  // it relies on the execute stage only splitting what was flagged
  always_comb
  begin
    a_be_nonzero : assert final (!data_req_i || (trans.trans_be != '0));
  end

endmodule

// File: lsu_trans_if.sv
`timescale 1ns/1ps

// one transaction request and its response
// request side is a plain valid/ready pair, response is a single strobe
interface lsu_trans_if;
  import lsu_pkg::*;

  logic            trans_valid;   // request present and a slot is free
  logic            trans_ready;   // bus grant
  logic [XLEN-1:0] trans_addr;    // byte address, word aligned in 2nd phase
  logic            trans_we;      // 1 = store
  logic [BE_W-1:0] trans_be;      // byte lanes touched
  logic [XLEN-1:0] trans_wdata;   // store data already in lane position

  logic            resp_valid;    // rvalid of the oldest outstanding txn
  logic [XLEN-1:0] resp_rdata;    // raw read word

  // request generator, fills in the payload of the request
  modport gen (
    output trans_addr, trans_we, trans_be, trans_wdata
  );

  // transaction controller, issues the request and returns the response
  modport ctrl (
    output trans_valid, resp_valid, resp_rdata,
    input  trans_ready, trans_addr, trans_we, trans_be, trans_wdata
  );

  // read data path only consumes responses
  modport sink (
    input resp_valid, resp_rdata
  );

endinterface

// File: lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  parameter int unsigned XLEN = 32;         // data and address width
  parameter int unsigned BE_W = XLEN / 8;   // one enable per byte lane

  // byte offset of an access inside one bus word
  typedef logic [$clog2(BE_W)-1:0] lsu_offset_t;

  //////////////////////////////
  // access size
  //////////////////////////////

  // code 2'b11 has no name of its own
  // decoders fall through to the byte case for it
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,   // 32 bit
    LSU_HALF = 2'b01,   // 16 bit
    LSU_BYTE = 2'b10    // 8 bit
  } lsu_type_e;

  //////////////////////////////
  // load extension mode
  //////////////////////////////

  // upper bits of a sub-word load are filled with zeros, ones or the msb
  // any code other than zero or ones fill means sign fill
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,   // zero fill
    EXT_SIGN = 2'b01,   // sign fill
    EXT_ONES = 2'b10    // ones fill
  } lsu_ext_e;

endpackage
